//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Bit timing
    localparam int TICK_DIV   = 4;     // clk cycles per oversample tick
    localparam int OVERSAMPLE = 16;    // Ticks per bit
    localparam int DATA_BITS  = 8;     // 8N1 only

    // Credit depths
    localparam int RX_CREDITS = 2;     // Echo buffer entries
    localparam int TX_DEPTH   = 4;     // Transmit FIFO entries

    localparam int RESET_STRETCH = 4;  // Extra clk edges of internal reset

    // Hex font table size
    localparam int FONT_DIGITS = 16;   // One glyph per nibble value
    localparam int SEG_WIDTH   = 8;    // Segments a..g plus decimal point

    // Counter widths and terminal values
    localparam int DIV_W    = $clog2(TICK_DIV);
    localparam int OS_W     = $clog2(OVERSAMPLE);
    localparam int BIT_W    = $clog2(DATA_BITS);
    localparam int RXC_W    = $clog2(RX_CREDITS + 1);
    localparam int TXC_W    = $clog2(TX_DEPTH + 1);
    localparam int RX_PTR_W = $clog2(RX_CREDITS);
    localparam int TX_PTR_W = $clog2(TX_DEPTH);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);
    localparam logic [OS_W-1:0]  OS_LAST  = OS_W'(OVERSAMPLE - 1);
    localparam logic [OS_W-1:0]  OS_HALF  = OS_W'(OVERSAMPLE / 2 - 1);  // Mid-bit of start
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_BITS - 1);

    localparam logic [RXC_W-1:0] RX_CRED_INIT = RXC_W'(RX_CREDITS);
    localparam logic [TXC_W-1:0] TX_CRED_INIT = TXC_W'(TX_DEPTH);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

//--- rtl/uart_link_if.sv
`default_nettype none

// Byte link from the receiver to the application, credit based
interface uart_link_if;

    logic                           valid;      // One-cycle byte strobe
    logic [uart_pkg::DATA_BITS-1:0] data;       // Received byte
    logic                           frame_err;  // Stop bit was low
    logic                           credit;     // One entry freed downstream

    // Credit sender side
    modport src (
        output valid,
        output data,
        output frame_err,
        input  credit
    );

    // Credit receiver side
    modport dst (
        input  valid,
        input  data,
        input  frame_err,
        output credit
    );

endinterface

`default_nettype wire

//--- rtl/reset_on_start.sv
`default_nettype none

// Asynchronous assert, synchronous release
module reset_on_start (
    input  logic clk,
    input  logic rst,
    output logic sys_rst
);

    logic [uart_pkg::RESET_STRETCH-1:0] stretch;  // Ones drain out one per edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stretch <= '1;                        // Force all stages high
        end else begin
            stretch <= {stretch[uart_pkg::RESET_STRETCH-2:0], 1'b0};
        end
    end

    // MSB is the last stage to clear
    assign sys_rst = stretch[uart_pkg::RESET_STRETCH-1];

endmodule

`default_nettype wire

//--- rtl/baud_tick_gen.sv
`default_nettype none

module baud_tick_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [uart_pkg::DIV_W-1:0] div_cnt;  // clk cycles within one tick period

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == uart_pkg::DIV_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // One-cycle strobe, shared by rx and tx
            tick <= (div_cnt == uart_pkg::DIV_LAST);
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`default_nettype none

// 8N1 receiver, 16x oversampled, credit sender on the link
module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            tick,
    input  logic            rxd,
    uart_link_if.src        link
);

    logic rx_meta;                              // First sync stage
    logic rx_sync;                              // Second sync stage
    logic rx_last;                              // For edge detect
    logic fall;                                 // Start bit edge

    uart_pkg::rx_state_t              state;
    logic [uart_pkg::OS_W-1:0]        tick_cnt;  // Ticks since last sample
    logic [uart_pkg::BIT_W-1:0]       bit_cnt;   // Data bit index
    logic [uart_pkg::DATA_BITS-1:0]   shift_reg; // LSB arrives first
    logic [uart_pkg::RXC_W-1:0]       credits;   // Free entries downstream
    logic                             bit_end;   // Full bit period elapsed
    logic                             take_bit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;                    // Line idles high
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign fall     = rx_last & ~rx_sync;
    assign bit_end  = tick && (tick_cnt == uart_pkg::OS_LAST);
    assign take_bit = (state == uart_pkg::RX_DATA) && bit_end;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= uart_pkg::RX_IDLE;
            tick_cnt       <= '0;
            bit_cnt        <= '0;
            link.valid     <= 1'b0;
            link.frame_err <= 1'b0;
        end else begin
            link.valid <= 1'b0;                 // Strobe by default
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (fall) begin             // Edge only, so a stuck-low line waits
                        state    <= uart_pkg::RX_START;
                        tick_cnt <= '0;
                    end
                end
                uart_pkg::RX_START: begin
                    if (tick) begin
                        if (tick_cnt == uart_pkg::OS_HALF) begin
                            // Still low at mid-bit means a real start bit
                            state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_cnt == uart_pkg::BIT_LAST) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin                  // RX_STOP
                    if (bit_end) begin
                        state <= uart_pkg::RX_IDLE;
                        if (credits != '0) begin   // Byte dropped without a credit
                            link.valid     <= 1'b1;
                            link.frame_err <= ~rx_sync;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_reg <= {rx_sync, shift_reg[uart_pkg::DATA_BITS-1:1]};
        end
    end

    assign link.data = shift_reg;               // Stable from valid until next frame

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= uart_pkg::RX_CRED_INIT;  // Whole echo buffer free
        end else begin
            case ({link.valid, link.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`default_nettype none

// Transmit FIFO plus 8N1 serializer
module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_credit,
    output logic       txd
);

    logic [uart_pkg::DATA_BITS-1:0] mem [uart_pkg::TX_DEPTH];
    logic [uart_pkg::TX_PTR_W-1:0]  wr_ptr;
    logic [uart_pkg::TX_PTR_W-1:0]  rd_ptr;
    logic [uart_pkg::TXC_W-1:0]     count;     // Entries held
    logic [uart_pkg::DATA_BITS-1:0] head;      // Byte on the wire

    uart_pkg::tx_state_t            state;
    logic [uart_pkg::OS_W-1:0]      tick_cnt;
    logic [uart_pkg::BIT_W-1:0]     bit_cnt;
    logic                           bit_end;
    logic                           pop;       // Stop bit done

    assign head    = mem[rd_ptr];
    assign bit_end = tick && (tick_cnt == uart_pkg::OS_LAST);
    assign pop     = (state == uart_pkg::TX_STOP) && bit_end;

    // Sender holds a credit, so a write always finds space
    always_ff @(posedge clk) begin
        if (tx_valid) begin
            mem[wr_ptr] <= tx_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            tx_credit <= 1'b0;
        end else begin
            if (tx_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;        // Entry kept until frame ends
            end
            case ({tx_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            tx_credit <= pop;                   // Credit back per finished frame
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;                   // Idle line
        end else begin
            if (tick && !bit_end) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (tick && count != '0) begin   // Align to tick boundary
                        state    <= uart_pkg::TX_START;
                        tick_cnt <= '0;
                        txd      <= 1'b0;       // Start bit
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state    <= uart_pkg::TX_DATA;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        txd      <= head[0];    // LSB first
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_cnt == uart_pkg::BIT_LAST) begin
                            state <= uart_pkg::TX_STOP;
                            txd   <= 1'b1;      // Stop bit
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= head[bit_cnt + 1'b1];
                        end
                    end
                end
                default: begin                  // TX_STOP
                    if (bit_end) begin
                        state    <= uart_pkg::TX_IDLE;
                        tick_cnt <= '0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/byte_display.sv
`default_nettype none

// Echo buffer, case converter, byte counters and hex display
module byte_display (
    input  logic       clk,
    input  logic       rst,
    uart_link_if.dst   link,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    input  logic       tx_credit,
    output logic [7:0] ss1,
    output logic [7:0] ss0,
    output logic [7:0] left,
    output logic [7:0] right
);

    logic [uart_pkg::DATA_BITS-1:0] fifo_mem [uart_pkg::RX_CREDITS];
    logic [uart_pkg::RX_PTR_W-1:0]  wr_ptr;
    logic [uart_pkg::RX_PTR_W-1:0]  rd_ptr;
    logic [uart_pkg::RXC_W-1:0]     fifo_count;  // Echo buffer occupancy
    logic [uart_pkg::TXC_W-1:0]     tx_cred;     // Free tx FIFO entries
    logic [uart_pkg::DATA_BITS-1:0] shown;       // Last good byte
    logic                           good;
    logic                           bad;
    logic                           send;

    // Active-high segments, bit 0 is a, bit 6 is g, no decimal point
    function automatic logic [uart_pkg::SEG_WIDTH-1:0] hex_seg(
        input logic [$clog2(uart_pkg::FONT_DIGITS)-1:0] nib
    );
        case (nib)
            4'h0:    hex_seg = 8'h3F;
            4'h1:    hex_seg = 8'h06;
            4'h2:    hex_seg = 8'h5B;
            4'h3:    hex_seg = 8'h4F;
            4'h4:    hex_seg = 8'h66;
            4'h5:    hex_seg = 8'h6D;
            4'h6:    hex_seg = 8'h7D;
            4'h7:    hex_seg = 8'h07;
            4'h8:    hex_seg = 8'h7F;
            4'h9:    hex_seg = 8'h6F;
            4'hA:    hex_seg = 8'h77;
            4'hB:    hex_seg = 8'h7C;             // Lower-case b
            4'hC:    hex_seg = 8'h39;
            4'hD:    hex_seg = 8'h5E;             // Lower-case d
            4'hE:    hex_seg = 8'h79;
            default: hex_seg = 8'h71;
        endcase
    endfunction

    // a..z becomes A..Z, everything else passes
    function automatic logic [7:0] to_upper(input logic [7:0] c);
        to_upper = (c >= 8'h61 && c <= 8'h7A) ? (c & 8'hDF) : c;
    endfunction

    assign good = link.valid & ~link.frame_err;
    assign bad  = link.valid & link.frame_err;
    // One send at a time, and never alongside an error credit
    assign send = (fifo_count != '0) && (tx_cred != '0) && !tx_valid && !bad;

    always_ff @(posedge clk) begin
        if (good) begin
            fifo_mem[wr_ptr] <= to_upper(link.data);
        end
        if (send) begin
            tx_data <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fifo_count  <= '0;
            tx_valid    <= 1'b0;
            link.credit <= 1'b0;
            shown       <= '0;
            left        <= '0;
            right       <= '0;
        end else begin
            if (good) begin
                wr_ptr <= wr_ptr + 1'b1;
                shown  <= link.data;          // Original byte, not the echo
                left   <= left + 1'b1;        // Wraps at 256
            end
            if (bad) begin
                right <= right + 1'b1;        // Dropped, only counted
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({good, send})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            tx_valid    <= send;
            link.credit <= send | bad;        // Entry freed or byte dropped
        end
    end

    // Credits into uart_tx, spent when tx_valid is seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_cred <= uart_pkg::TX_CRED_INIT;
        end else begin
            case ({tx_valid, tx_credit})
                2'b10:   tx_cred <= tx_cred - 1'b1;
                2'b01:   tx_cred <= tx_cred + 1'b1;
                default: tx_cred <= tx_cred;
            endcase
        end
    end

    assign ss1 = hex_seg(shown[7:4]);         // High nibble
    assign ss0 = hex_seg(shown[3:0]);

endmodule

`default_nettype wire

//--- rtl/uart_board_top.sv
`default_nettype none

// Serial echo terminal, board-level wrapper
module uart_board_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       tx,
    output logic       cts_n,
    output logic [7:0] ss1,
    output logic [7:0] ss0,
    output logic [7:0] left,
    output logic [7:0] right
);

    logic       sys_rst;      // Stretched, synchronously released
    logic       tick;         // 16x oversample strobe
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_credit;

    uart_link_if link_if ();  // rx to application

    assign cts_n = 1'b0;      // Sender never needs to pause

    reset_on_start reset_inst (
        .clk     (clk),
        .rst     (rst),
        .sys_rst (sys_rst)
    );

    baud_tick_gen tick_inst (
        .clk  (clk),
        .rst  (sys_rst),
        .tick (tick)
    );

    uart_rx rx_inst (
        .clk  (clk),
        .rst  (sys_rst),
        .tick (tick),
        .rxd  (rx),
        .link (link_if.src)
    );

    byte_display display_inst (
        .clk       (clk),
        .rst       (sys_rst),
        .link      (link_if.dst),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .ss1       (ss1),
        .ss0       (ss0),
        .left      (left),
        .right     (right)
    );

    uart_tx tx_inst (
        .clk       (clk),
        .rst       (sys_rst),
        .tick      (tick),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .txd       (tx)
    );

endmodule

`default_nettype wire

//--- bench/uart_board_sva.sv
`default_nettype none

// Credit and pulse rules around the echo buffer
module byte_display_sva (
    input logic                       clk,
    input logic                       rst,
    input logic                       tx_valid,
    input logic                       link_credit,
    input logic [uart_pkg::TXC_W-1:0] tx_cred,
    input logic [uart_pkg::RXC_W-1:0] fifo_count
);

    int unsigned fail_count = 0;  // Assertion failures so far

    // A byte goes to uart_tx only while it has a free entry
    tx_needs_credit: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_valid) |-> (tx_cred != '0))
        else begin
            fail_count++;
            $error("tx_valid rose with zero tx credits");
        end

    fifo_bound: assert property (@(posedge clk) disable iff (rst)
        fifo_count <= uart_pkg::RX_CREDITS)   // Echo buffer never overfills
        else begin
            fail_count++;
            $error("Echo buffer above its depth");
        end

    credit_pulse: assert property (@(posedge clk) disable iff (rst)
        link_credit |=> !link_credit)
        else begin
            fail_count++;
            $error("link credit held for two cycles");
        end

    tx_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        tx_valid |=> !tx_valid)
        else begin
            fail_count++;
            $error("tx_valid held for two cycles");
        end

endmodule

bind byte_display byte_display_sva sva_inst (
    .clk         (clk),
    .rst         (rst),
    .tx_valid    (tx_valid),
    .link_credit (link.credit),
    .tx_cred     (tx_cred),
    .fifo_count  (fifo_count)
);

`default_nettype wire

//--- bench/uart_board_tb.sv
`default_nettype none

module uart_board_tb;

    localparam int BIT_CYCLES   = uart_pkg::TICK_DIV * uart_pkg::OVERSAMPLE;  // 64 clk
    localparam int FRAME_CYCLES = BIT_CYCLES * 10;                           // 8N1 frame
    localparam int MAX_CYCLES   = 40000;  // About 30 frames each way plus margin

    logic       clk;
    logic       rst;
    logic       rx;
    logic       tx;
    logic       cts_n;
    logic [7:0] ss1;
    logic [7:0] ss0;
    logic [7:0] left;
    logic [7:0] right;

    logic [7:0] exp_q [$];    // Echo bytes still to come
    integer     seed;
    int         cycle_count;

    uart_board_top uart_board_top_inst (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .tx    (tx),
        .cts_n (cts_n),
        .ss1   (ss1),
        .ss0   (ss0),
        .left  (left),
        .right (right)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                $display("Timeout after %0d cycles, test did not finish", cycle_count);
                $display("*** FAILED ***");
                $fatal(1);
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // Upper-case letters echo, a framing error echoes nothing
    function automatic bit expect_echo(input logic [7:0] b, input bit stop_ok,
                                       output logic [7:0] echo);
        expect_echo = stop_ok;
        if (b >= 8'h61 && b <= 8'h7A) echo = b - 8'h20;   // 'a'..'z'
        else echo = b;
    endfunction

    // Segments a..g on bits 0..6, decimal point off
    function automatic logic [7:0] hex_font(input logic [3:0] n);
        case (n)
            4'h0: hex_font = 8'h3F;
            4'h1: hex_font = 8'h06;
            4'h2: hex_font = 8'h5B;
            4'h3: hex_font = 8'h4F;
            4'h4: hex_font = 8'h66;
            4'h5: hex_font = 8'h6D;
            4'h6: hex_font = 8'h7D;
            4'h7: hex_font = 8'h07;
            4'h8: hex_font = 8'h7F;
            4'h9: hex_font = 8'h6F;
            4'hA: hex_font = 8'h77;
            4'hB: hex_font = 8'h7C;
            4'hC: hex_font = 8'h39;
            4'hD: hex_font = 8'h5E;
            4'hE: hex_font = 8'h79;
            default: hex_font = 8'h71;
        endcase
    endfunction

    // Lands 1 time unit after the nth rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drive_frame(input logic [7:0] b, input bit stop_ok);
        int i;
        rx = 1'b0;                            // Start bit
        wait_cycles(BIT_CYCLES);
        for (i = 0; i < 8; i++) begin
            rx = b[i];                        // LSB first
            wait_cycles(BIT_CYCLES);
        end
        rx = stop_ok;                         // Low here forces a framing error
        wait_cycles(BIT_CYCLES);
        rx = 1'b1;
    endtask

    task automatic send_byte(input logic [7:0] b, input bit stop_ok);
        logic [7:0] echo;
        if (expect_echo(b, stop_ok, echo)) exp_q.push_back(echo);
        drive_frame(b, stop_ok);
    endtask

    task automatic wait_echoes();
        while (exp_q.size() != 0) wait_cycles(1);
        wait_cycles(BIT_CYCLES);              // Rest of the last stop bit
    endtask

    task automatic check_reset_state();
        check_val("tx", tx, 1'b1);
        check_val("cts_n", cts_n, 1'b0);
        check_val("left", left, 8'h00);
        check_val("right", right, 8'h00);
        check_val("ss1", ss1, hex_font(4'h0));
        check_val("ss0", ss0, hex_font(4'h0));
    endtask

    // Echo monitor, samples tx at mid-bit on falling clock edges
    initial begin
        logic [7:0] got;
        int i;
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);
                check_val("tx start bit", tx, 1'b0);
                for (i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    got[i] = tx;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("Bad stop bit on tx, line not high at mid-stop");
                    $display("*** FAILED ***");
                    $fatal(1);
                end
                if (exp_q.size() == 0) begin
                    $display("Echo 0x%0h seen on tx when none was expected", got);
                    $display("*** FAILED ***");
                    $fatal(1);
                end
                check_val("tx echo", got, exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [7:0] b;
        int n;
        seed = 12;
        rst  = 1'b1;
        rx   = 1'b1;                          // Idle line
        wait_cycles(10);
        rst = 1'b0;
        wait_cycles(uart_pkg::RESET_STRETCH + 2);
        check_reset_state();

        send_byte(8'h61, 1'b1);               // 'a' comes back as 'A'
        wait_echoes();
        check_val("ss1", ss1, hex_font(4'h6));
        check_val("ss0", ss0, hex_font(4'h1));
        check_val("left", left, 8'd1);

        for (n = 0; n < 20; n++) begin        // Back to back frames
            b = $random(seed);
            send_byte(b, 1'b1);
        end
        wait_echoes();
        check_val("left", left, 8'd21);
        check_val("ss1", ss1, hex_font(b[7:4]));
        check_val("ss0", ss0, hex_font(b[3:0]));

        send_byte(8'h55, 1'b0);
        wait_cycles(2 * FRAME_CYCLES);        // Room for a stray echo to show up
        check_val("right", right, 8'd1);
        check_val("left", left, 8'd21);
        check_val("ss1", ss1, hex_font(b[7:4]));   // Still the last good byte
        check_val("ss0", ss0, hex_font(b[3:0]));
        send_byte(8'h7A, 1'b1);
        wait_echoes();
        check_val("left", left, 8'd22);
        check_val("right", right, 8'd1);

        rx = 1'b0;                            // Reset lands inside a frame
        wait_cycles(3 * BIT_CYCLES);
        rst = 1'b1;
        wait_cycles(5);
        rx = 1'b1;
        wait_cycles(5);
        rst = 1'b0;
        wait_cycles(uart_pkg::RESET_STRETCH + 2);
        check_reset_state();
        send_byte(8'h62, 1'b1);
        wait_echoes();
        check_val("left", left, 8'd1);
        check_val("ss1", ss1, hex_font(4'h6));
        check_val("ss0", ss0, hex_font(4'h2));

        if (uart_board_top_inst.display_inst.sva_inst.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("%0d assertion failures in byte_display",
                     uart_board_top_inst.display_inst.sva_inst.fail_count);
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rtl/uart_pkg.sv
rtl/uart_link_if.sv
rtl/reset_on_start.sv
rtl/baud_tick_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/byte_display.sv
rtl/uart_board_top.sv
bench/uart_board_sva.sv
bench/uart_board_tb.sv
